// File: verification/ex_input.txt
# pc alu br rs1 rs2 use_rs1 use_rs2 imm rd rd_wen, then expected data, redirect flag, target (hex)
# alu: 0 add 1 sub 2 and 3 or 4 xor 5 sll 6 srl 7 sra 8 slt 9 sltu a pass_b; br: 0 none 1 beq 2 bne 3 blt 4 bge 5 jal 6 jalr
00000100 0 0 00 00 1 0 12345678 01 1 12345678 0 00000000
00000104 a 0 00 00 1 0 fffff000 02 1 fffff000 0 00000000
00000108 0 0 01 02 1 1 00000000 03 1 12344678 0 00000000
0000010c 1 0 03 01 1 1 00000000 04 1 fffff000 0 00000000
00000110 2 0 04 01 1 1 00000000 05 1 12345000 0 00000000
00000114 3 0 05 00 1 0 000000ff 06 1 123450ff 0 00000000
00000118 4 0 06 01 1 1 00000000 07 1 00000687 0 00000000
0000011c 5 0 07 00 1 0 00000004 08 1 00006870 0 00000000
00000120 6 0 02 00 1 0 00000008 09 1 00fffff0 0 00000000
00000124 7 0 02 00 1 0 00000008 0a 1 fffffff0 0 00000000
00000128 8 0 02 01 1 1 00000000 0b 1 00000001 0 00000000
0000012c 9 0 02 01 1 1 00000000 0c 1 00000000 0 00000000
00000130 0 0 01 00 1 0 00000000 00 1 12345678 0 00000000
00000134 0 0 00 00 1 0 00000005 0d 1 00000005 0 00000000
00000138 0 0 00 00 0 0 00002000 0e 1 00002138 0 00000000
0000013c 0 1 01 01 1 1 00000010 00 0 2468acf0 1 0000014c
0000014c 1 2 01 01 1 1 00000008 00 0 00000000 0 00000000
00000150 1 3 02 01 1 1 fffffff0 00 0 edcb9988 1 00000140
00000140 4 4 01 02 1 1 00000020 00 0 edcba678 1 00000160
00000160 0 5 00 00 0 0 00000040 0f 1 00000164 1 000001a0
000001a0 0 6 0e 00 1 0 00000011 10 1 000001a4 1 00002148
00002148 0 0 10 0f 1 1 00000000 11 1 00000308 0 00000000
0000214c 0 4 11 01 1 1 00000008 00 0 12345980 0 00000000
00002150 3 0 00 0d 1 1 00000000 12 1 00000005 0 00000000

// File: flist.f
verilog/ex_pkg.sv
verilog/reg_file.sv
verilog/ex_forward.sv
verilog/ex_alu.sv
verilog/ex_branch.sv
verilog/ex_stage.sv
verilog/retire_stage.sv
verilog/ex_top.sv
verification/tb_ex_top.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute subsystem testbench with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_ex_top -f flist.f -o sim_ex_top
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_ex_top)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -q "^Regression passed$"; then
  exit 0
fi
exit 1

// File: verification/tb_ex_top.sv
// testbench for ex_top, replays the vector file twice, first with retire always ready, then stalled
`timescale 1ns/10ps

module tb_ex_top;
  import ex_pkg::*;

  localparam int max_vec = 64;
  localparam int num_passes = 2;

  logic                  clk;
  logic                  rst;
  logic                  in_valid;
  logic [xlen-1:0]       in_pc;
  logic [alu_op_w-1:0]   in_alu_op;
  logic [br_op_w-1:0]    in_br_op;
  logic [reg_addr_w-1:0] in_rs1;
  logic [reg_addr_w-1:0] in_rs2;
  logic                  in_use_rs1;
  logic                  in_use_rs2;
  logic [xlen-1:0]       in_imm;
  logic [reg_addr_w-1:0] in_rd;
  logic                  in_rd_wen;
  logic                  ex_allowin;
  logic                  retire_valid;
  logic [xlen-1:0]       retire_pc;
  logic [reg_addr_w-1:0] retire_rd;
  logic                  retire_wen;
  logic [xlen-1:0]       retire_data;
  logic                  retire_ready;
  logic                  redirect_valid;
  logic [xlen-1:0]       redirect_pc;

  // one array per column of the vector file
  logic [xlen-1:0] vec_pc    [max_vec];
  logic [xlen-1:0] vec_alu   [max_vec];
  logic [xlen-1:0] vec_br    [max_vec];
  logic [xlen-1:0] vec_rs1   [max_vec];
  logic [xlen-1:0] vec_rs2   [max_vec];
  logic [xlen-1:0] vec_use1  [max_vec];
  logic [xlen-1:0] vec_use2  [max_vec];
  logic [xlen-1:0] vec_imm   [max_vec];
  logic [xlen-1:0] vec_rd    [max_vec];
  logic [xlen-1:0] vec_wen   [max_vec];
  logic [xlen-1:0] vec_data  [max_vec];
  logic [xlen-1:0] vec_redir [max_vec];
  logic [xlen-1:0] vec_tgt   [max_vec];

  // expected retire records and redirect targets, in issue order
  logic [xlen-1:0] exp_pc   [$];
  logic [xlen-1:0] exp_rd   [$];
  logic [xlen-1:0] exp_wen  [$];
  logic [xlen-1:0] exp_data [$];
  logic [xlen-1:0] exp_tgt  [$];

  int num_vec;
  int errors;
  int checks;
  int retired;
  int redirects;
  bit loaded;
  bit stall_on;

  // retire outputs seen in a stalled cycle
  bit                    held;
  logic [xlen-1:0]       held_pc;
  logic [reg_addr_w-1:0] held_rd;
  logic                  held_wen;
  logic [xlen-1:0]       held_data;

  ex_top UUT (.*);

  always #2 clk = ~clk;

  // ready low about one cycle in four while stalls are on
  always @(posedge clk) begin
    #1;
    if (stall_on) begin
      retire_ready = ($urandom % 4) != 0;
    end else begin
      retire_ready = 1'b1;
    end
  end

  task automatic compare_value(input string name, input logic [xlen-1:0] got,
                               input logic [xlen-1:0] expected);
    checks++;
    if (got !== expected) begin
      $display("CHECK FAILED %s: got %h, expected %h at %0t", name, got, expected, $time);
      errors++;
    end
  endtask

  task automatic check_retire;
    if (exp_pc.size() == 0) begin
      $display("retirement at pc %h with no instruction outstanding", retire_pc);
      errors++;
    end else begin
      compare_value("retire_pc", retire_pc, exp_pc.pop_front());
      compare_value("retire_rd", xlen'(retire_rd), exp_rd.pop_front());
      compare_value("retire_wen", xlen'(retire_wen), exp_wen.pop_front());
      compare_value("retire_data", retire_data, exp_data.pop_front());
      retired++;
    end
  endtask

  task automatic check_redirect;
    if (exp_tgt.size() == 0) begin
      $display("unexpected redirect strobe to %h at %0t", redirect_pc, $time);
      errors++;
    end else begin
      compare_value("redirect_pc", redirect_pc, exp_tgt.pop_front());
      redirects++;
    end
  endtask

  // sampled mid cycle, a handshake seen here completes at the next rising edge
  always @(negedge clk) begin
    if (rst) begin
      held = 1'b0;
    end else begin
      if (held) begin
        compare_value("stalled retire_valid", xlen'(retire_valid), 1);
        compare_value("stalled retire_pc", retire_pc, held_pc);
        compare_value("stalled retire_rd", xlen'(retire_rd), xlen'(held_rd));
        compare_value("stalled retire_wen", xlen'(retire_wen), xlen'(held_wen));
        compare_value("stalled retire_data", retire_data, held_data);
      end
      if (retire_valid && retire_ready) begin
        check_retire();
      end
      if (redirect_valid) begin
        check_redirect();
      end
      held      = retire_valid && !retire_ready;
      held_pc   = retire_pc;
      held_rd   = retire_rd;
      held_wen  = retire_wen;
      held_data = retire_data;
    end
  end

  task automatic load_vectors;
    int    fd;
    int    cnt;
    string line;
    fd = $fopen("verification/ex_input.txt", "r");
    if (fd == 0) begin
      $display("cannot open the vector file verification/ex_input.txt");
      errors++;
      return;
    end
    while ($fgets(line, fd) != 0 && num_vec < max_vec) begin
      if (line.len() > 1 && line.getc(0) != "#") begin
        cnt = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h",
                      vec_pc[num_vec], vec_alu[num_vec], vec_br[num_vec], vec_rs1[num_vec],
                      vec_rs2[num_vec], vec_use1[num_vec], vec_use2[num_vec],
                      vec_imm[num_vec], vec_rd[num_vec], vec_wen[num_vec],
                      vec_data[num_vec], vec_redir[num_vec], vec_tgt[num_vec]);
        if (cnt == 13) begin
          num_vec++;
        end else begin
          $display("malformed vector line: %s", line);
          errors++;
        end
      end
    end
    $fclose(fd);
  endtask

  task automatic issue_vector(input int i);
    in_valid   = 1'b1;
    in_pc      = vec_pc[i];
    in_alu_op  = vec_alu[i][alu_op_w-1:0];
    in_br_op   = vec_br[i][br_op_w-1:0];
    in_rs1     = vec_rs1[i][reg_addr_w-1:0];
    in_rs2     = vec_rs2[i][reg_addr_w-1:0];
    in_use_rs1 = vec_use1[i][0];
    in_use_rs2 = vec_use2[i][0];
    in_imm     = vec_imm[i];
    in_rd      = vec_rd[i][reg_addr_w-1:0];
    in_rd_wen  = vec_wen[i][0];
    @(negedge clk);
    while (!ex_allowin) begin
      @(negedge clk);
    end
    // accepted at this edge
    @(posedge clk);
    #1;
    in_valid = 1'b0;
    exp_pc.push_back(vec_pc[i]);
    exp_rd.push_back(vec_rd[i]);
    exp_wen.push_back(vec_wen[i]);
    exp_data.push_back(vec_data[i]);
    if (vec_redir[i][0]) begin
      exp_tgt.push_back(vec_tgt[i]);
    end
  endtask

  task automatic apply_reset;
    rst = 1'b1;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    compare_value("retire_valid after reset", xlen'(retire_valid), 0);
    compare_value("redirect_valid after reset", xlen'(redirect_valid), 0);
    compare_value("ex_allowin after reset", xlen'(ex_allowin), 1);
    @(posedge clk);
    #1;
  endtask

  task automatic drain;
    while (exp_pc.size() != 0) begin
      @(negedge clk);
    end
    repeat (2) @(posedge clk);
    #1;
    if (exp_tgt.size() != 0) begin
      $display("%0d redirect strobes never appeared", exp_tgt.size());
      errors++;
      exp_tgt.delete();
    end
  endtask

  initial begin
    int limit;
    wait (loaded);
    limit = (num_vec + 1) * 20 * num_passes;
    repeat (limit) @(posedge clk);
    $display("timeout after %0d cycles, errors %0d, retired %0d", limit, errors, retired);
    $display("Regression failed");
    $finish;
  end

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    in_valid     = 1'b0;
    in_pc        = '0;
    in_alu_op    = '0;
    in_br_op     = '0;
    in_rs1       = '0;
    in_rs2       = '0;
    in_use_rs1   = 1'b0;
    in_use_rs2   = 1'b0;
    in_imm       = '0;
    in_rd        = '0;
    in_rd_wen    = 1'b0;
    retire_ready = 1'b1;
    stall_on     = 1'b0;
    void'($urandom(53));
    load_vectors();
    if (num_vec == 0) begin
      $display("no vectors were loaded");
      errors++;
    end
    loaded = 1'b1;
    // register file is cleared by each reset, so both passes expect the same values
    for (int p = 0; p < num_passes; p++) begin
      stall_on = (p != 0);
      apply_reset();
      for (int i = 0; i < num_vec; i++) begin
        issue_vector(i);
      end
      drain();
    end
    if (retired != num_vec * num_passes) begin
      $display("retired %0d instructions, issued %0d", retired, num_vec * num_passes);
      errors++;
    end
    $display("errors %0d, checks %0d, retired %0d, redirects %0d",
             errors, checks, retired, redirects);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// File: verilog/ex_top.sv
// top of the execute subsystem, wires execute, retire and the register file together
`timescale 1ns/10ps

module ex_top (
  input  logic                          clk,
  input  logic                          rst,
  // issue port
  input  logic                          in_valid,
  input  logic [ex_pkg::xlen-1:0]       in_pc,
  input  logic [ex_pkg::alu_op_w-1:0]   in_alu_op,
  input  logic [ex_pkg::br_op_w-1:0]    in_br_op,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rs1,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rs2,
  input  logic                          in_use_rs1,
  input  logic                          in_use_rs2,
  input  logic [ex_pkg::xlen-1:0]       in_imm,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rd,
  input  logic                          in_rd_wen,
  output logic                          ex_allowin,
  // retire port
  output logic                          retire_valid,
  output logic [ex_pkg::xlen-1:0]       retire_pc,
  output logic [ex_pkg::reg_addr_w-1:0] retire_rd,
  output logic                          retire_wen,
  output logic [ex_pkg::xlen-1:0]       retire_data,
  input  logic                          retire_ready,
  // redirect
  output logic                          redirect_valid,
  output logic [ex_pkg::xlen-1:0]       redirect_pc
);
  import ex_pkg::*;

  logic [reg_addr_w-1:0] rs1_addr;
  logic [reg_addr_w-1:0] rs2_addr;
  logic [xlen-1:0]       rs1_data;
  logic [xlen-1:0]       rs2_data;

  logic                  ex_to_rt_valid;
  logic [xlen-1:0]       ex_to_rt_pc;
  logic [reg_addr_w-1:0] ex_to_rt_rd;
  logic                  ex_to_rt_wen;
  logic [xlen-1:0]       ex_to_rt_data;
  logic                  rt_allowin;

  logic                  rf_wen;
  logic [reg_addr_w-1:0] rf_waddr;
  logic [xlen-1:0]       rf_wdata;

  logic                  fwd_valid;
  logic [reg_addr_w-1:0] fwd_rd;
  logic [xlen-1:0]       fwd_data;

  reg_file u_reg_file (
    .clk    (clk),
    .rst    (rst),
    .raddr1 (rs1_addr),
    .raddr2 (rs2_addr),
    .rdata1 (rs1_data),
    .rdata2 (rs2_data),
    .wen    (rf_wen),
    .waddr  (rf_waddr),
    .wdata  (rf_wdata)
  );

  ex_stage u_ex_stage (
    .clk            (clk),
    .rst            (rst),
    .in_valid       (in_valid),
    .in_pc          (in_pc),
    .in_alu_op      (in_alu_op),
    .in_br_op       (in_br_op),
    .in_rs1         (in_rs1),
    .in_rs2         (in_rs2),
    .in_use_rs1     (in_use_rs1),
    .in_use_rs2     (in_use_rs2),
    .in_imm         (in_imm),
    .in_rd          (in_rd),
    .in_rd_wen      (in_rd_wen),
    .ex_allowin     (ex_allowin),
    .rs1_addr       (rs1_addr),
    .rs2_addr       (rs2_addr),
    .rs1_data       (rs1_data),
    .rs2_data       (rs2_data),
    .fwd_valid      (fwd_valid),
    .fwd_rd         (fwd_rd),
    .fwd_data       (fwd_data),
    .ex_to_rt_valid (ex_to_rt_valid),
    .ex_to_rt_pc    (ex_to_rt_pc),
    .ex_to_rt_rd    (ex_to_rt_rd),
    .ex_to_rt_wen   (ex_to_rt_wen),
    .ex_to_rt_data  (ex_to_rt_data),
    .rt_allowin     (rt_allowin),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  retire_stage u_retire_stage (
    .clk            (clk),
    .rst            (rst),
    .ex_to_rt_valid (ex_to_rt_valid),
    .ex_to_rt_pc    (ex_to_rt_pc),
    .ex_to_rt_rd    (ex_to_rt_rd),
    .ex_to_rt_wen   (ex_to_rt_wen),
    .ex_to_rt_data  (ex_to_rt_data),
    .rt_allowin     (rt_allowin),
    .retire_valid   (retire_valid),
    .retire_pc      (retire_pc),
    .retire_rd      (retire_rd),
    .retire_wen     (retire_wen),
    .retire_data    (retire_data),
    .retire_ready   (retire_ready),
    .rf_wen         (rf_wen),
    .rf_waddr       (rf_waddr),
    .rf_wdata       (rf_wdata),
    .fwd_valid      (fwd_valid),
    .fwd_rd         (fwd_rd),
    .fwd_data       (fwd_data)
  );

endmodule

// File: verilog/retire_stage.sv
// retire buffer between execute and the outside, drives the register write and the bypass
`timescale 1ns/10ps

module retire_stage (
  input  logic                          clk,
  input  logic                          rst,
  // from execute
  input  logic                          ex_to_rt_valid,
  input  logic [ex_pkg::xlen-1:0]       ex_to_rt_pc,
  input  logic [ex_pkg::reg_addr_w-1:0] ex_to_rt_rd,
  input  logic                          ex_to_rt_wen,
  input  logic [ex_pkg::xlen-1:0]       ex_to_rt_data,
  output logic                          rt_allowin,
  // retire port
  output logic                          retire_valid,
  output logic [ex_pkg::xlen-1:0]       retire_pc,
  output logic [ex_pkg::reg_addr_w-1:0] retire_rd,
  output logic                          retire_wen,
  output logic [ex_pkg::xlen-1:0]       retire_data,
  input  logic                          retire_ready,
  // register file write
  output logic                          rf_wen,
  output logic [ex_pkg::reg_addr_w-1:0] rf_waddr,
  output logic [ex_pkg::xlen-1:0]       rf_wdata,
  // bypass to execute
  output logic                          fwd_valid,
  output logic [ex_pkg::reg_addr_w-1:0] fwd_rd,
  output logic [ex_pkg::xlen-1:0]       fwd_data
);

  logic rt_valid;

  assign rt_allowin = !rt_valid || retire_ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      rt_valid <= 1'b0;
    end else if (rt_allowin) begin
      rt_valid <= ex_to_rt_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (ex_to_rt_valid && rt_allowin) begin
      retire_pc   <= ex_to_rt_pc;
      retire_rd   <= ex_to_rt_rd;
      retire_wen  <= ex_to_rt_wen;
      retire_data <= ex_to_rt_data;
    end
  end

  assign retire_valid = rt_valid;

  // write happens on the same edge the instruction leaves
  assign rf_wen   = rt_valid && retire_ready && retire_wen;
  assign rf_waddr = retire_rd;
  assign rf_wdata = retire_data;

  // bypass stays live for the whole stall
  assign fwd_valid = rt_valid && retire_wen;
  assign fwd_rd    = retire_rd;
  assign fwd_data  = retire_data;

  a_stall_stable: assert property (@(posedge clk) disable iff (rst)
    (retire_valid && !retire_ready) |=>
      (retire_valid && $stable(retire_pc) && $stable(retire_rd) &&
       $stable(retire_wen) && $stable(retire_data)))
    else $error("retire_stage: outputs changed while stalled");

endmodule

// File: verilog/ex_stage.sv
// execute pipeline stage, holds one issued instruction and computes its result and redirect
`timescale 1ns/10ps

module ex_stage (
  input  logic                          clk,
  input  logic                          rst,
  // issue side
  input  logic                          in_valid,
  input  logic [ex_pkg::xlen-1:0]       in_pc,
  input  logic [ex_pkg::alu_op_w-1:0]   in_alu_op,
  input  logic [ex_pkg::br_op_w-1:0]    in_br_op,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rs1,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rs2,
  input  logic                          in_use_rs1,
  input  logic                          in_use_rs2,
  input  logic [ex_pkg::xlen-1:0]       in_imm,
  input  logic [ex_pkg::reg_addr_w-1:0] in_rd,
  input  logic                          in_rd_wen,
  output logic                          ex_allowin,
  // register file reads
  output logic [ex_pkg::reg_addr_w-1:0] rs1_addr,
  output logic [ex_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [ex_pkg::xlen-1:0]       rs1_data,
  input  logic [ex_pkg::xlen-1:0]       rs2_data,
  // bypass from retire
  input  logic                          fwd_valid,
  input  logic [ex_pkg::reg_addr_w-1:0] fwd_rd,
  input  logic [ex_pkg::xlen-1:0]       fwd_data,
  // to retire
  output logic                          ex_to_rt_valid,
  output logic [ex_pkg::xlen-1:0]       ex_to_rt_pc,
  output logic [ex_pkg::reg_addr_w-1:0] ex_to_rt_rd,
  output logic                          ex_to_rt_wen,
  output logic [ex_pkg::xlen-1:0]       ex_to_rt_data,
  input  logic                          rt_allowin,
  // fetch redirect
  output logic                          redirect_valid,
  output logic [ex_pkg::xlen-1:0]       redirect_pc
);
  import ex_pkg::*;

  logic                  ex_valid;
  logic [xlen-1:0]       pc_q;
  logic [alu_op_w-1:0]   alu_op_q;
  logic [br_op_w-1:0]    br_op_q;
  logic [reg_addr_w-1:0] rs1_q;
  logic [reg_addr_w-1:0] rs2_q;
  logic                  use_rs1_q;
  logic                  use_rs2_q;
  logic [xlen-1:0]       imm_q;
  logic [reg_addr_w-1:0] rd_q;
  logic                  rd_wen_q;

  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_result;
  logic            br_taken;
  logic [xlen-1:0] br_target;
  logic            is_jump;

  // single cycle stage, ready_go is always true
  assign ex_allowin = !ex_valid || rt_allowin;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_valid <= 1'b0;
    end else if (ex_allowin) begin
      ex_valid <= in_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (in_valid && ex_allowin) begin
      pc_q      <= in_pc;
      alu_op_q  <= in_alu_op;
      br_op_q   <= in_br_op;
      rs1_q     <= in_rs1;
      rs2_q     <= in_rs2;
      use_rs1_q <= in_use_rs1;
      use_rs2_q <= in_use_rs2;
      imm_q     <= in_imm;
      rd_q      <= in_rd;
      rd_wen_q  <= in_rd_wen;
    end
  end

  assign rs1_addr = rs1_q;
  assign rs2_addr = rs2_q;

  ex_forward u_forward (
    .rs1_addr  (rs1_q),
    .rs2_addr  (rs2_q),
    .rs1_data  (rs1_data),
    .rs2_data  (rs2_data),
    .fwd_valid (fwd_valid),
    .fwd_rd    (fwd_rd),
    .fwd_data  (fwd_data),
    .rs1_val   (rs1_val),
    .rs2_val   (rs2_val)
  );

  // auipc style ops take the pc as operand a
  assign op_a = use_rs1_q ? rs1_val : pc_q;
  assign op_b = use_rs2_q ? rs2_val : imm_q;

  ex_alu u_alu (
    .op_a   (op_a),
    .op_b   (op_b),
    .alu_op (alu_op_q),
    .result (alu_result)
  );

  ex_branch u_branch (
    .br_op   (br_op_q),
    .pc      (pc_q),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val),
    .imm     (imm_q),
    .taken   (br_taken),
    .target  (br_target)
  );

  // jumps write the link address instead of the alu result
  assign is_jump = (br_op_q == br_jal) || (br_op_q == br_jalr);

  assign ex_to_rt_valid = ex_valid;
  assign ex_to_rt_pc    = pc_q;
  assign ex_to_rt_rd    = rd_q;
  assign ex_to_rt_wen   = rd_wen_q;
  assign ex_to_rt_data  = is_jump ? pc_q + xlen'(inst_len) : alu_result;

  // strobe on the handover edge only, so one pulse per taken branch
  assign redirect_valid = ex_valid && br_taken && rt_allowin;
  assign redirect_pc    = br_target;

  // a blocked full stage keeps its instruction over the next edge
  a_hold_when_blocked: assert property (@(posedge clk) disable iff (rst)
    (ex_valid && !rt_allowin) |=> (ex_valid && $stable(pc_q) && $stable(rd_q)))
    else $error("ex_stage: instruction replaced while blocked");

  // only a valid branch or jump may redirect
  a_redirect_valid: assert property (@(posedge clk) disable iff (rst)
    redirect_valid |-> (ex_valid && (br_op_q != br_none)))
    else $error("ex_stage: redirect without a valid branch");

endmodule

// File: verilog/ex_branch.sv
// branch resolution, decides taken and computes the redirect target
`timescale 1ns/10ps

module ex_branch (
  input  logic [ex_pkg::br_op_w-1:0] br_op,
  input  logic [ex_pkg::xlen-1:0]    pc,
  input  logic [ex_pkg::xlen-1:0]    rs1_val,
  input  logic [ex_pkg::xlen-1:0]    rs2_val,
  input  logic [ex_pkg::xlen-1:0]    imm,
  output logic                       taken,
  output logic [ex_pkg::xlen-1:0]    target
);
  import ex_pkg::*;

  logic            eq;
  logic            lt;
  logic [xlen-1:0] jalr_sum;

  assign eq       = rs1_val == rs2_val;
  assign lt       = $signed(rs1_val) < $signed(rs2_val);
  assign jalr_sum = rs1_val + imm;

  always_comb begin
    case (br_op)
      br_beq:  taken = eq;
      br_bne:  taken = !eq;
      br_blt:  taken = lt;
      br_bge:  taken = !lt;
      br_jal,
      br_jalr: taken = 1'b1;
      default: taken = 1'b0;
    endcase
  end

  // jalr clears bit 0 of the sum
  assign target = (br_op == br_jalr) ? {jalr_sum[xlen-1:1], 1'b0} : pc + imm;

endmodule

// File: verilog/ex_alu.sv
// integer ALU of the execute stage, purely combinational
`timescale 1ns/10ps

module ex_alu (
  input  logic [ex_pkg::xlen-1:0]     op_a,
  input  logic [ex_pkg::xlen-1:0]     op_b,
  input  logic [ex_pkg::alu_op_w-1:0] alu_op,
  output logic [ex_pkg::xlen-1:0]     result
);
  import ex_pkg::*;

  logic [4:0] shamt;
  logic       lt_signed;
  logic       lt_unsigned;

  // rv32 uses the low five bits as shift amount
  assign shamt       = op_b[4:0];
  assign lt_signed   = $signed(op_a) < $signed(op_b);
  assign lt_unsigned = op_a < op_b;

  always_comb begin
    case (alu_op)
      alu_add:    result = op_a + op_b;
      alu_sub:    result = op_a - op_b;
      alu_and:    result = op_a & op_b;
      alu_or:     result = op_a | op_b;
      alu_xor:    result = op_a ^ op_b;
      alu_sll:    result = op_a << shamt;
      alu_srl:    result = op_a >> shamt;
      alu_sra:    result = $unsigned($signed(op_a) >>> shamt);
      alu_slt:    result = {{(xlen-1){1'b0}}, lt_signed};
      alu_sltu:   result = {{(xlen-1){1'b0}}, lt_unsigned};
      alu_pass_b: result = op_b;
      default:    result = '0;
    endcase
  end

  // codes above pass_b are not produced by decode
  always_comb begin
    assert ($isunknown(alu_op) || alu_op <= alu_pass_b)
      else $error("ex_alu: unknown operation code %0d", alu_op);
  end

endmodule

// File: verilog/ex_forward.sv
// operand bypass for the execute stage, overrides register file reads with the retiring result
`timescale 1ns/10ps

module ex_forward (
  input  logic [ex_pkg::reg_addr_w-1:0] rs1_addr,
  input  logic [ex_pkg::reg_addr_w-1:0] rs2_addr,
  input  logic [ex_pkg::xlen-1:0]       rs1_data,
  input  logic [ex_pkg::xlen-1:0]       rs2_data,
  input  logic                          fwd_valid,
  input  logic [ex_pkg::reg_addr_w-1:0] fwd_rd,
  input  logic [ex_pkg::xlen-1:0]       fwd_data,
  output logic [ex_pkg::xlen-1:0]       rs1_val,
  output logic [ex_pkg::xlen-1:0]       rs2_val
);

  logic fwd_live;
  logic hit1;
  logic hit2;

  // x0 writes are dropped, so never bypass them
  assign fwd_live = fwd_valid && (fwd_rd != '0);

  assign hit1 = fwd_live && (fwd_rd == rs1_addr);
  assign hit2 = fwd_live && (fwd_rd == rs2_addr);

  // only one producer ahead of execute, no priority chain needed
  assign rs1_val = hit1 ? fwd_data : rs1_data;
  assign rs2_val = hit2 ? fwd_data : rs2_data;

endmodule

// File: verilog/reg_file.sv
// general purpose register file, two combinational read ports and one write port from retire
`timescale 1ns/10ps

module reg_file (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [ex_pkg::reg_addr_w-1:0] raddr1,
  input  logic [ex_pkg::reg_addr_w-1:0] raddr2,
  output logic [ex_pkg::xlen-1:0]       rdata1,
  output logic [ex_pkg::xlen-1:0]       rdata2,
  input  logic                          wen,
  input  logic [ex_pkg::reg_addr_w-1:0] waddr,
  input  logic [ex_pkg::xlen-1:0]       wdata
);
  import ex_pkg::*;

  localparam int num_regs = 1 << reg_addr_w;

  logic [xlen-1:0] regs [num_regs];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < num_regs; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != '0) begin
      // x0 never written, stays zero after reset
      regs[waddr] <= wdata;
    end
  end

  // new value visible the cycle after the write edge
  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule

// File: verilog/ex_pkg.sv
// shared widths and operation encodings, imported by every RTL module of the execute subsystem
package ex_pkg;

  // data and address width
  localparam int xlen = 32;

  // register index width
  localparam int reg_addr_w = 5;

  // alu operation codes
  localparam int alu_op_w = 4;
  localparam logic [alu_op_w-1:0] alu_add    = 4'd0;
  localparam logic [alu_op_w-1:0] alu_sub    = 4'd1;
  localparam logic [alu_op_w-1:0] alu_and    = 4'd2;
  localparam logic [alu_op_w-1:0] alu_or     = 4'd3;
  localparam logic [alu_op_w-1:0] alu_xor    = 4'd4;
  localparam logic [alu_op_w-1:0] alu_sll    = 4'd5;
  localparam logic [alu_op_w-1:0] alu_srl    = 4'd6;
  localparam logic [alu_op_w-1:0] alu_sra    = 4'd7;
  localparam logic [alu_op_w-1:0] alu_slt    = 4'd8;
  localparam logic [alu_op_w-1:0] alu_sltu   = 4'd9;
  // lui style, result is operand b
  localparam logic [alu_op_w-1:0] alu_pass_b = 4'd10;

  // branch and jump codes
  localparam int br_op_w = 3;
  localparam logic [br_op_w-1:0] br_none = 3'd0;
  localparam logic [br_op_w-1:0] br_beq  = 3'd1;
  localparam logic [br_op_w-1:0] br_bne  = 3'd2;
  localparam logic [br_op_w-1:0] br_blt  = 3'd3;
  localparam logic [br_op_w-1:0] br_bge  = 3'd4;
  localparam logic [br_op_w-1:0] br_jal  = 3'd5;
  localparam logic [br_op_w-1:0] br_jalr = 3'd6;

  // bytes per instruction, link offset
  localparam int inst_len = 4;

endpackage
